//--- verilog/blur_pkg.sv
`default_nettype none

package blur_pkg;

    // One RGB444 pixel, red in the top nibble, then green, then blue
    typedef logic [11:0] pixel_t;

    // One colour component of a pixel
    typedef logic [3:0] channel_t;

    // Weighted channel sum before normalisation, up to 15 * 64
    typedef logic [9:0] wsum_t;

    // Filter mode
    typedef enum logic [1:0] {
        BLUR_NONE = 2'd0,
        BLUR_3X3  = 2'd1,
        BLUR_5X5  = 2'd2
    } blur_mode_t;

    // One stream beat with its side-band flags
    typedef struct packed {
        logic   valid;
        logic   sop;
        logic   eop;
        pixel_t data;
    } video_beat_t;

endpackage

`default_nettype wire

//--- verilog/blur_config.sv
`timescale 1ns/1ns
`default_nettype none

module blur_config (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_write,
    input  blur_pkg::blur_mode_t cfg_mode,
    input  logic                 frame_start,
    output blur_pkg::blur_mode_t active_mode
);
    import blur_pkg::*;

    // Last mode written, waiting for the next frame
    blur_mode_t pending_q;

    // Pending register, loaded by the write strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= BLUR_NONE;
        end else if (cfg_write) begin
            pending_q <= cfg_mode;
        end
    end

    // The active mode changes only at a frame boundary,
    // so a write in mid-frame is seen by the next frame only
    always_ff @(posedge clk) begin
        if (reset) begin
            active_mode <= BLUR_NONE;
        end else if (frame_start) begin
            active_mode <= pending_q;
        end
    end

endmodule

`default_nettype wire

//--- verilog/line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer #(
    parameter int image_width = 320
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        advance,
    input  blur_pkg::video_beat_t       beat_in,
    output blur_pkg::video_beat_t [4:0] column
);
    import blur_pkg::*;

    // Four chained delay lines, one image line each
    video_beat_t line_q [4][image_width];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 4; r++) begin
                for (int i = 0; i < image_width; i++) begin
                    line_q[r][i] <= '0;
                end
            end
        end else if (advance) begin
            // Line 0 takes the new beat, each later line takes the tail of the one above
            line_q[0][0] <= beat_in;
            for (int r = 1; r < 4; r++) begin
                line_q[r][0] <= line_q[r-1][image_width-1];
            end
            for (int r = 0; r < 4; r++) begin
                for (int i = 1; i < image_width; i++) begin
                    line_q[r][i] <= line_q[r][i-1];
                end
            end
        end
    end

    // Row 0 is the incoming beat, row r is r lines older
    always_comb begin
        column[0] = beat_in;
        for (int r = 0; r < 4; r++) begin
            column[r+1] = line_q[r][image_width-1];
        end
    end

endmodule

`default_nettype wire

//--- verilog/window_5x5.sv
`timescale 1ns/1ns
`default_nettype none

module window_5x5 (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         advance,
    input  blur_pkg::video_beat_t [4:0]  column,
    output blur_pkg::video_beat_t [24:0] window,
    output blur_pkg::video_beat_t        center
);
    import blur_pkg::*;

    // Column 0 is the newest column
    video_beat_t [4:0] col_q [5];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < 5; c++) begin
                col_q[c] <= '0;
            end
        end else if (advance) begin
            col_q[0] <= column;
            for (int c = 1; c < 5; c++) begin
                col_q[c] <= col_q[c-1];
            end
        end
    end

    // Flatten row-major, index row * 5 + col
    always_comb begin
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                window[r*5+c] = col_q[c][r];
            end
        end
    end

    assign center = col_q[2][2];

endmodule

`default_nettype wire

//--- verilog/channel_convolver.sv
`timescale 1ns/1ns
`default_nettype none

module channel_convolver (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       advance,
    input  blur_pkg::blur_mode_t       mode,
    input  blur_pkg::channel_t [24:0]  taps,
    output blur_pkg::channel_t         result
);
    import blur_pkg::*;

    // Stage 1 products, 15 * 4 fits in 6 bits
    logic [5:0] prod_q [25];
    // Stage 2 row sums, 15 * 18 fits in 9 bits
    logic [8:0] row_sum [5];
    logic [8:0] row_q [5];
    wsum_t      total;

    // Mode and centre tap travel with their beat
    blur_mode_t mode_s1_q;
    blur_mode_t mode_s2_q;
    channel_t   center_s1_q;
    channel_t   center_s2_q;

    // Weights grow by one per step in from the edge, capped at 4
    function automatic logic [2:0] kernel_weight(input int row, input int col,
                                                 input blur_mode_t m);
        int         ring;
        logic [2:0] w;
        ring = 1 + ((row < 2) ? row : 4 - row) + ((col < 2) ? col : 4 - col);
        w = (ring > 4) ? 3'd4 : 3'(ring);
        // 3x3 uses only the inner ring
        if (m == BLUR_3X3 && (row == 0 || row == 4 || col == 0 || col == 4)) begin
            w = 3'd0;
        end
        return w;
    endfunction

    // Stage 1: weight each tap
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 25; i++) begin
                prod_q[i] <= '0;
            end
            mode_s1_q   <= BLUR_NONE;
            center_s1_q <= '0;
        end else if (advance) begin
            for (int i = 0; i < 25; i++) begin
                prod_q[i] <= 6'(taps[i]) * 6'(kernel_weight(i / 5, i % 5, mode));
            end
            mode_s1_q   <= mode;
            center_s1_q <= taps[12];
        end
    end

    always_comb begin
        for (int r = 0; r < 5; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < 5; c++) begin
                row_sum[r] = row_sum[r] + 9'(prod_q[r*5+c]);
            end
        end
    end

    // Stage 2: row sums
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 5; r++) begin
                row_q[r] <= '0;
            end
            mode_s2_q   <= BLUR_NONE;
            center_s2_q <= '0;
        end else if (advance) begin
            row_q       <= row_sum;
            mode_s2_q   <= mode_s1_q;
            center_s2_q <= center_s1_q;
        end
    end

    always_comb begin
        total = '0;
        for (int r = 0; r < 5; r++) begin
            total = total + wsum_t'(row_q[r]);
        end
    end

    // Stage 3: total and normalise, 64 for 5x5 and 32 for 3x3
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (advance) begin
            case (mode_s2_q)
                BLUR_5X5: result <= total[9:6];
                BLUR_3X3: result <= total[8:5];
                default:  result <= center_s2_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/blur_filter.sv
`timescale 1ns/1ns
`default_nettype none

module blur_filter #(
    parameter int image_width = 320
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid_in,
    input  logic                 sop_in,
    input  logic                 eop_in,
    input  blur_pkg::pixel_t     data_in,
    input  logic                 ready_in,
    input  blur_pkg::blur_mode_t active_mode,
    output logic                 frame_start,
    output logic                 valid_out,
    output logic                 sop_out,
    output logic                 eop_out,
    output blur_pkg::pixel_t     data_out
);
    import blur_pkg::*;

    logic               advance;
    video_beat_t        beat_in;
    video_beat_t [4:0]  column;
    video_beat_t [24:0] window;
    video_beat_t        center;

    channel_t [24:0] red_taps;
    channel_t [24:0] green_taps;
    channel_t [24:0] blue_taps;
    channel_t        red_result;
    channel_t        green_result;
    channel_t        blue_result;

    // Centre flags, two stages here and the third in the output register
    logic [1:0] valid_sb;
    logic [1:0] sop_sb;
    logic [1:0] eop_sb;

    // The whole pipeline steps only on an accepted beat
    assign advance = valid_in && ready_in;

    assign beat_in = '{valid: valid_in, sop: sop_in, eop: eop_in, data: data_in};

    line_buffer #(
        .image_width(image_width)
    ) u_line_buffer (
        .clk    (clk),
        .reset  (reset),
        .advance(advance),
        .beat_in(beat_in),
        .column (column)
    );

    window_5x5 u_window (
        .clk    (clk),
        .reset  (reset),
        .advance(advance),
        .column (column),
        .window (window),
        .center (center)
    );

    // Beat at row 2, column 1 is the next centre
    assign frame_start = advance && window[11].valid && window[11].sop;

    always_comb begin
        for (int i = 0; i < 25; i++) begin
            red_taps[i]   = window[i].data[11:8];
            green_taps[i] = window[i].data[7:4];
            blue_taps[i]  = window[i].data[3:0];
        end
    end

    channel_convolver u_conv_red (
        .clk    (clk),
        .reset  (reset),
        .advance(advance),
        .mode   (active_mode),
        .taps   (red_taps),
        .result (red_result)
    );

    channel_convolver u_conv_green (
        .clk    (clk),
        .reset  (reset),
        .advance(advance),
        .mode   (active_mode),
        .taps   (green_taps),
        .result (green_result)
    );

    channel_convolver u_conv_blue (
        .clk    (clk),
        .reset  (reset),
        .advance(advance),
        .mode   (active_mode),
        .taps   (blue_taps),
        .result (blue_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sb <= '0;
            sop_sb   <= '0;
            eop_sb   <= '0;
        end else if (advance) begin
            valid_sb <= {valid_sb[0], center.valid};
            sop_sb   <= {sop_sb[0], center.sop};
            eop_sb   <= {eop_sb[0], center.eop};
        end
    end

    // Output strobes last one cycle, aligned with the stage 3 results
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            sop_out   <= 1'b0;
            eop_out   <= 1'b0;
        end else begin
            valid_out <= advance && valid_sb[1];
            sop_out   <= advance && valid_sb[1] && sop_sb[1];
            eop_out   <= advance && valid_sb[1] && eop_sb[1];
        end
    end

    assign data_out = {red_result, green_result, blue_result};

endmodule

`default_nettype wire

//--- verilog/blur_top.sv
`timescale 1ns/1ns
`default_nettype none

module blur_top #(
    parameter int image_width = 320
) (
    input  logic                 clk,
    input  logic                 reset,
    // Upstream stream
    input  logic                 valid_in,
    input  logic                 sop_in,
    input  logic                 eop_in,
    input  blur_pkg::pixel_t     data_in,
    output logic                 ready_out,
    // Downstream stream
    input  logic                 ready_in,
    output logic                 valid_out,
    output logic                 sop_out,
    output logic                 eop_out,
    output blur_pkg::pixel_t     data_out,
    // Configuration
    input  logic                 cfg_write,
    input  blur_pkg::blur_mode_t cfg_mode
);
    import blur_pkg::*;

    logic       frame_start;
    blur_mode_t active_mode;

    // No buffering, so back-pressure goes straight upstream
    assign ready_out = ready_in;

    blur_config u_config (
        .clk        (clk),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_mode   (cfg_mode),
        .frame_start(frame_start),
        .active_mode(active_mode)
    );

    blur_filter #(
        .image_width(image_width)
    ) u_filter (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (valid_in),
        .sop_in     (sop_in),
        .eop_in     (eop_in),
        .data_in    (data_in),
        .ready_in   (ready_in),
        .active_mode(active_mode),
        .frame_start(frame_start),
        .valid_out  (valid_out),
        .sop_out    (sop_out),
        .eop_out    (eop_out),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

//--- testbench/blur_model.svh
`ifndef BLUR_MODEL_SVH
`define BLUR_MODEL_SVH

// Accepted beats in order, with the test each one belongs to
pixel_t     hist_data[$];
logic       hist_sop[$];
logic       hist_eop[$];
int         hist_test[$];
logic       hist_flat[$];
// Mode each centre beat is filtered with, same index as hist_data
blur_mode_t mode_q[$];
blur_mode_t model_pending = BLUR_NONE;
blur_mode_t model_active = BLUR_NONE;

localparam int kernel_w[5][5] = '{
    '{1, 2, 3, 2, 1},
    '{2, 3, 4, 3, 2},
    '{3, 4, 4, 4, 3},
    '{2, 3, 4, 3, 2},
    '{1, 2, 3, 2, 1}
};

// Centre trails the newest beat by two lines and two pixels
function automatic void record_beat(input pixel_t d, input logic s, input logic e,
                                    input int test, input logic flat);
    int c;
    hist_data.push_back(d);
    hist_sop.push_back(s);
    hist_eop.push_back(e);
    hist_test.push_back(test);
    hist_flat.push_back(flat);
    c = hist_data.size() - 1 - (2 * image_width + 2);
    if (c >= 0) begin
        // A frame start reaching the centre picks up the last written mode
        if (hist_sop[c]) begin
            model_active = model_pending;
        end
        mode_q.push_back(model_active);
    end
endfunction

// Zero before the first beat, like the cleared line buffers
function automatic int hist_channel(input int idx, input int ch);
    return (idx < 0) ? 0 : int'(hist_data[idx][ch*4 +: 4]);
endfunction

function automatic pixel_t expected_pixel(input int c);
    int     reach;
    int     sum;
    pixel_t p;
    if (mode_q[c] == BLUR_NONE) begin
        return hist_data[c];
    end
    reach = (mode_q[c] == BLUR_5X5) ? 2 : 1;
    for (int ch = 0; ch < 3; ch++) begin
        sum = 0;
        for (int dr = -reach; dr <= reach; dr++) begin
            for (int dc = -reach; dc <= reach; dc++) begin
                sum += kernel_w[dr+2][dc+2] * hist_channel(c + dr * image_width + dc, ch);
            end
        end
        // Weights sum to 64 for 5x5, 32 for the inner 3x3
        p[ch*4 +: 4] = 4'((reach == 2) ? (sum >> 6) : (sum >> 5));
    end
    return p;
endfunction

`endif

//--- testbench/blur_tb.sv
`timescale 1ns/1ns
`default_nettype none

module blur_tb;
    import blur_pkg::*;

    localparam int image_width = 16;
    localparam int frame_beats = image_width * 8;
    localparam int clk_period  = 4;
    // Reset, nine frames, about two extra cycles per stalled beat, mode writes
    localparam int stim_cycles = 16 + 9 * frame_beats + 4 * frame_beats + 8;

    logic       clk = 1'b0;
    logic       reset, valid_in, sop_in, eop_in, ready_in, ready_out, cfg_write;
    logic       valid_out, sop_out, eop_out;
    pixel_t     data_in, data_out;
    blur_mode_t cfg_mode;

    // Checker state
    int     out_idx = 0;
    int     errors = 0;
    int     tests_passed = 0;
    int     cur_test = 0;
    int     exp_test = 0;
    int     fails[7] = '{default: 0};
    int     checks[7] = '{default: 0};
    int     test_last[7] = '{default: 0};
    logic   flat_mark = 1'b0;
    logic   exp_known = 1'b0;
    logic   exp_sop, exp_eop, exp_flat, ready_q;
    pixel_t exp_data;
    string  test_names[7] = '{"none", "pass_through", "flat_3x3", "random_5x5",
                              "mode_timing", "stalls", "flush"};

    `include "blur_model.svh"

    blur_top #(.image_width(image_width)) dut (
        .clk(clk), .reset(reset),
        .valid_in(valid_in), .sop_in(sop_in), .eop_in(eop_in), .data_in(data_in),
        .ready_out(ready_out), .ready_in(ready_in),
        .valid_out(valid_out), .sop_out(sop_out), .eop_out(eop_out), .data_out(data_out),
        .cfg_write(cfg_write), .cfg_mode(cfg_mode)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic value_mismatch(input int test, input string what, input int expv,
                                  input int actv);
        errors++;
        fails[test]++;
        $display("[FAIL] %s %s expected %0h actual %0h", test_names[test], what, expv, actv);
    endtask

    task automatic note_error(input string what);
        errors++;
        fails[exp_test]++;
        $display("Error in %s: %s", test_names[exp_test], what);
    endtask

    task automatic report_test(input int t);
        if (fails[t] == 0) begin
            tests_passed++;
        end
        $display("test %s %s, %0d beats checked, %0d errors", test_names[t],
                 (fails[t] == 0) ? "passed" : "failed", checks[t], fails[t]);
    endtask

    // Holds the beat until accepted, with optional gaps and back-pressure
    task automatic send_beat(input pixel_t d, input logic s, input logic e, input bit stall);
        bit done;
        done = 1'b0;
        while (!done) begin
            ready_in = stall ? ($urandom % 4 != 0) : 1'b1;
            valid_in = !stall || ($urandom % 4 != 0);
            sop_in   = s;
            eop_in   = e;
            data_in  = d;
            done     = valid_in && ready_in;
            @(negedge clk);
        end
        valid_in = 1'b0;
    endtask

    task automatic write_mode(input blur_mode_t m);
        cfg_write = 1'b1;
        cfg_mode  = m;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    task automatic send_frame(input bit flat, input bit check_flat, input bit stall,
                              input bit mid_write, input blur_mode_t mid_mode);
        for (int i = 0; i < frame_beats; i++) begin
            if (mid_write && i == frame_beats / 2) begin
                write_mode(mid_mode);
            end
            // Pixels whose whole 3x3 neighbourhood lies in flat frames
            flat_mark = check_flat && (i / image_width) inside {[1:6]}
                        && (i % image_width) inside {[1:image_width-2]};
            send_beat(flat ? 12'hF85 : 12'($urandom), i == 0, i == frame_beats - 1, stall);
        end
        test_last[cur_test] = hist_data.size() - 1;
    endtask

    // Monitor: feeds the model and lines up the next expected beat
    always @(posedge clk) begin
        ready_q <= ready_in;
        if (!reset) begin
            if (valid_in && ready_in) begin
                record_beat(data_in, sop_in, eop_in, cur_test, flat_mark);
            end
            if (cfg_write) begin
                model_pending = cfg_mode;
            end
            if (valid_out) begin
                // A test is complete once the first beat of the next one comes out
                if (out_idx > 0 && hist_test[out_idx] != hist_test[out_idx-1]) begin
                    report_test(hist_test[out_idx-1]);
                end
                checks[hist_test[out_idx]]++;
                out_idx++;
            end
            exp_known <= mode_q.size() > out_idx;
            if (mode_q.size() > out_idx) begin
                exp_data <= expected_pixel(out_idx);
                exp_sop  <= hist_sop[out_idx];
                exp_eop  <= hist_eop[out_idx];
                exp_flat <= hist_flat[out_idx];
                exp_test <= hist_test[out_idx];
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) valid_out |-> exp_known)
        else note_error("valid_out rose with no beat left to expect");
    assert property (@(posedge clk) disable iff (reset)
                     valid_out && exp_known |-> data_out == exp_data)
        else value_mismatch($sampled(exp_test), "data_out", $sampled(exp_data),
                            $sampled(data_out));
    assert property (@(posedge clk) disable iff (reset)
                     valid_out && exp_known |-> sop_out == exp_sop)
        else value_mismatch($sampled(exp_test), "sop_out", $sampled(exp_sop),
                            $sampled(sop_out));
    assert property (@(posedge clk) disable iff (reset)
                     valid_out && exp_known |-> eop_out == exp_eop)
        else value_mismatch($sampled(exp_test), "eop_out", $sampled(exp_eop),
                            $sampled(eop_out));
    assert property (@(posedge clk) disable iff (reset)
                     valid_out && exp_known && exp_flat |-> data_out == 12'hF85)
        else value_mismatch($sampled(exp_test), "flat data_out", 12'hF85, $sampled(data_out));
    // A result leaves only after an accepted beat
    assert property (@(posedge clk) disable iff (reset) valid_out |-> ready_q)
        else note_error("valid_out rose after a cycle with ready_in low");
    assert property (@(posedge clk) ready_out == ready_in)
        else note_error("ready_out does not follow ready_in");

    initial begin
        void'($urandom(32'hbb29));
        reset     = 1'b1;
        valid_in  = 1'b0;
        sop_in    = 1'b0;
        eop_in    = 1'b0;
        data_in   = '0;
        ready_in  = 1'b1;
        cfg_write = 1'b0;
        cfg_mode  = BLUR_NONE;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        cur_test = 1;
        send_frame(1'b0, 1'b0, 1'b0, 1'b0, BLUR_NONE);
        cur_test = 2;
        write_mode(BLUR_3X3);
        send_frame(1'b1, 1'b0, 1'b0, 1'b0, BLUR_NONE);
        send_frame(1'b1, 1'b1, 1'b0, 1'b0, BLUR_NONE);
        cur_test = 3;
        write_mode(BLUR_5X5);
        send_frame(1'b0, 1'b0, 1'b0, 1'b0, BLUR_NONE);
        // Write half way through a 5x5 frame, the next frame turns 3x3
        cur_test = 4;
        send_frame(1'b0, 1'b0, 1'b0, 1'b1, BLUR_3X3);
        send_frame(1'b0, 1'b0, 1'b0, 1'b0, BLUR_NONE);
        cur_test = 5;
        write_mode(BLUR_5X5);
        send_frame(1'b0, 1'b0, 1'b1, 1'b0, BLUR_NONE);
        send_frame(1'b0, 1'b0, 1'b1, 1'b0, BLUR_NONE);
        ready_in = 1'b1;
        // Trailing frame pushes the last real beats out
        cur_test = 6;
        send_frame(1'b0, 1'b0, 1'b0, 1'b0, BLUR_NONE);
        while (out_idx < test_last[5] + 2) begin
            @(posedge clk);
        end
        repeat (2) @(negedge clk);
        $display("Summary: %0d of 5 tests passed, %0d beats checked, %0d errors",
                 tests_passed, out_idx, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(4 * stim_cycles * clk_period);
        $display("Timeout: outputs stopped before every beat was checked, %0d of %0d seen",
                 out_idx, test_last[5] + 2);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+testbench
verilog/blur_pkg.sv
verilog/blur_config.sv
verilog/line_buffer.sv
verilog/window_5x5.sv
verilog/channel_convolver.sv
verilog/blur_filter.sv
verilog/blur_top.sv
testbench/blur_tb.sv
